// File: sys_defs_pkg.sv
package sys_defs_pkg;

	// memory bus commands, shared by processor side and memory side
	typedef enum logic [1:0]
	{
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_e;

	// one block is one 64-bit word
	typedef logic [63:0] word_t;

	// block address, a word index
	typedef logic [31:0] addr_t;

	// transaction tag, zero means none
	typedef logic [3:0] mem_tag_t;

	// processor to cache
	typedef struct packed
	{
		bus_command_e command;
		addr_t        addr;
		word_t        data;
	} proc_req_t;

	// cache to processor
	typedef struct packed
	{
		word_t    data;
		logic     hit;
		mem_tag_t response;
		mem_tag_t tag;
	} proc_rsp_t;

	// line store lookup result
	typedef struct packed
	{
		word_t data;
		logic  valid;
		logic  dirty;
		logic  miss;
		addr_t victim_addr;
	} cache_lookup_t;

	// line store write port
	typedef struct packed
	{
		logic  enable;
		addr_t addr;
		word_t data;
		logic  dirty;
		logic  invalidate;
	} cache_write_t;

	// cache to memory
	typedef struct packed
	{
		bus_command_e command;
		addr_t        addr;
		word_t        data;
	} mem_req_t;

	// memory to cache
	typedef struct packed
	{
		mem_tag_t response;
		mem_tag_t tag;
		word_t    data;
	} mem_rsp_t;

endpackage

// File: dcache_mem.sv
`timescale 1ns/1ps

module dcache_mem
#(
	parameter int INDEX_BITS = 4
)
(
	input  logic                         clock,
	input  logic                         rst_n,
	input  sys_defs_pkg::addr_t          lookup_addr,
	output sys_defs_pkg::cache_lookup_t  lookup,
	input  sys_defs_pkg::cache_write_t   cache_wr
);
	import sys_defs_pkg::*;

	localparam int LINES    = 1 << INDEX_BITS;
	localparam int TAG_BITS = $bits(addr_t) - INDEX_BITS;

	word_t               data_mem [LINES];
	logic [TAG_BITS-1:0] tag_mem  [LINES];
	logic [LINES-1:0]    valid_q;
	logic [LINES-1:0]    dirty_q;

	logic [INDEX_BITS-1:0] rd_index;
	logic [TAG_BITS-1:0]   rd_tag;
	logic [INDEX_BITS-1:0] wr_index;
	logic [TAG_BITS-1:0]   wr_tag;

	// block address splits into tag over index
	assign rd_index = lookup_addr[INDEX_BITS-1:0];
	assign rd_tag   = lookup_addr[$bits(addr_t)-1:INDEX_BITS];
	assign wr_index = cache_wr.addr[INDEX_BITS-1:0];
	assign wr_tag   = cache_wr.addr[$bits(addr_t)-1:INDEX_BITS];

	always_comb
	begin
		lookup.data        = data_mem[rd_index];
		lookup.valid       = valid_q[rd_index];
		// dirty only counts on a valid line
		lookup.dirty       = valid_q[rd_index] && dirty_q[rd_index];
		lookup.miss        = !valid_q[rd_index] || (tag_mem[rd_index] != rd_tag);
		// address of whatever line sits at this index
		lookup.victim_addr = {tag_mem[rd_index], rd_index};
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (cache_wr.enable)
		begin
			valid_q[wr_index] <= 1'b1;
			dirty_q[wr_index] <= cache_wr.dirty;
		end
		else if (cache_wr.invalidate)
		begin
			valid_q[wr_index] <= 1'b0;
			dirty_q[wr_index] <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (cache_wr.enable)
		begin
			data_mem[wr_index] <= cache_wr.data;
			tag_mem[wr_index]  <= wr_tag;
		end
	end

	// controller never fills and drops a line at once
	assert property (@(posedge clock) disable iff (!rst_n)
		!(cache_wr.enable && cache_wr.invalidate))
		else $error("cache write with both enable and invalidate");

endmodule

// File: dmem_model.sv
`timescale 1ns/1ps

module dmem_model
#(
	parameter int MEM_LATENCY   = 4,
	parameter int MEM_ADDR_BITS = 10
)
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  sys_defs_pkg::mem_req_t  mem_req,
	output sys_defs_pkg::mem_rsp_t  mem_rsp
);
	import sys_defs_pkg::*;

	localparam int WORDS = 1 << MEM_ADDR_BITS;

	word_t    mem_array [WORDS];
	mem_tag_t next_tag;
	mem_tag_t pipe_tag  [MEM_LATENCY];
	addr_t    pipe_addr [MEM_LATENCY];

	logic accept;
	logic tag_busy;

	assign accept = (mem_req.command != BUS_NONE);

	// tag handed out in the same cycle as the command
	assign mem_rsp.response = accept ? next_tag : '0;
	assign mem_rsp.tag      = pipe_tag[MEM_LATENCY-1];
	// read at pipeline exit so earlier stores are seen
	assign mem_rsp.data     = mem_array[pipe_addr[MEM_LATENCY-1][MEM_ADDR_BITS-1:0]];

	always_comb
	begin
		tag_busy = 1'b0;
		for (int i = 0; i < MEM_LATENCY; i++)
		begin
			if (pipe_tag[i] == next_tag)
			begin
				tag_busy = 1'b1;
			end
		end
	end

	// tag counter wraps 15 back to 1
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			next_tag <= mem_tag_t'(1);
		end
		else if (accept)
		begin
			next_tag <= (next_tag == mem_tag_t'(15)) ? mem_tag_t'(1) : next_tag + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < MEM_LATENCY; i++)
			begin
				pipe_tag[i] <= '0;
			end
		end
		else
		begin
			pipe_tag[0] <= (mem_req.command == BUS_LOAD) ? next_tag : '0;
			for (int i = 1; i < MEM_LATENCY; i++)
			begin
				pipe_tag[i] <= pipe_tag[i-1];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		pipe_addr[0] <= mem_req.addr;
		for (int i = 1; i < MEM_LATENCY; i++)
		begin
			pipe_addr[i] <= pipe_addr[i-1];
		end
	end

	// word a holds a in both halves after reset
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < WORDS; i++)
			begin
				mem_array[i] <= {addr_t'(i), addr_t'(i)};
			end
		end
		else if (mem_req.command == BUS_STORE)
		begin
			mem_array[mem_req.addr[MEM_ADDR_BITS-1:0]] <= mem_req.data;
		end
	end

	// with latency under 15 a new tag is never still in the pipeline
	assert property (@(posedge clock) disable iff (!rst_n)
		accept |-> !tag_busy)
		else $error("tag %0d reused in flight, MEM_LATENCY=%0d", next_tag, MEM_LATENCY);

endmodule

// File: dcache_controller.sv
`timescale 1ns/1ps

module dcache_controller
(
	input  logic                         clock,
	input  logic                         rst_n,
	input  sys_defs_pkg::proc_req_t      proc_req,
	output sys_defs_pkg::proc_rsp_t      proc_rsp,
	output sys_defs_pkg::addr_t          lookup_addr,
	input  sys_defs_pkg::cache_lookup_t  lookup,
	output sys_defs_pkg::cache_write_t   cache_wr,
	output sys_defs_pkg::mem_req_t       mem_req,
	input  sys_defs_pkg::mem_rsp_t       mem_rsp
);
	import sys_defs_pkg::*;

	// block address of each outstanding load, indexed by its tag
	addr_t      pend_addr [1:15];
	logic [15:1] pend_valid;

	logic  fill_active;
	addr_t fill_addr;
	logic  load_accepted;

	assign fill_active = (mem_rsp.tag != '0);
	assign fill_addr   = pend_addr[mem_rsp.tag];

	// in a fill cycle the lookup port checks the line being filled
	assign lookup_addr = fill_active ? fill_addr : proc_req.addr;

	assign load_accepted = (mem_req.command == BUS_LOAD) && (mem_rsp.response != '0);

	always_comb
	begin
		mem_req.command     = BUS_NONE;
		mem_req.addr        = proc_req.addr;
		mem_req.data        = proc_req.data;

		cache_wr.enable     = 1'b0;
		cache_wr.addr       = proc_req.addr;
		cache_wr.data       = proc_req.data;
		cache_wr.dirty      = 1'b0;
		cache_wr.invalidate = 1'b0;

		proc_rsp.data       = lookup.data;
		proc_rsp.hit        = 1'b0;
		proc_rsp.response   = '0;
		// finished earlier load, if any
		proc_rsp.tag        = mem_rsp.tag;

		if (fill_active)
		begin
			// fill owns the write port, any request here sees a retry
			proc_rsp.data = mem_rsp.data;
			cache_wr.addr = fill_addr;
			cache_wr.data = mem_rsp.data;
			// a line dirtied since the load went out is newer than the fill
			cache_wr.enable = !(lookup.valid && lookup.dirty);
		end
		else
		begin
			case (proc_req.command)
				BUS_LOAD, BUS_STORE:
				begin
					if (!lookup.miss)
					begin
						proc_rsp.hit = 1'b1;
						if (proc_req.command == BUS_STORE)
						begin
							cache_wr.enable = 1'b1;
							cache_wr.dirty  = 1'b1;
						end
					end
					else if (!lookup.dirty)
					begin
						// clean miss, fetch the requested block
						mem_req.command   = BUS_LOAD;
						proc_rsp.response = mem_rsp.response;
					end
					else
					begin
						// dirty miss, write the victim back and drop it
						mem_req.command     = BUS_STORE;
						mem_req.addr        = lookup.victim_addr;
						mem_req.data        = lookup.data;
						cache_wr.invalidate = 1'b1;
						proc_rsp.response   = mem_rsp.response;
					end
				end
				default:
				begin
					mem_req.command = BUS_NONE;
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend_valid <= '0;
		end
		else
		begin
			if (fill_active)
			begin
				pend_valid[mem_rsp.tag] <= 1'b0;
			end
			if (load_accepted)
			begin
				pend_valid[mem_rsp.response] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (load_accepted)
		begin
			pend_addr[mem_rsp.response] <= mem_req.addr;
		end
	end

	// every completion matches a load this controller sent out
	assert property (@(posedge clock) disable iff (!rst_n)
		(mem_rsp.tag != '0) |-> pend_valid[mem_rsp.tag])
		else $error("completion for tag %0d with no pending load", mem_rsp.tag);

	assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown(mem_req.command))
		else $error("memory command is unknown");

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top
#(
	parameter int INDEX_BITS    = 4,
	parameter int MEM_LATENCY   = 4,
	parameter int MEM_ADDR_BITS = 10
)
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  sys_defs_pkg::proc_req_t  proc_req,
	output sys_defs_pkg::proc_rsp_t  proc_rsp
);
	import sys_defs_pkg::*;

	addr_t         lookup_addr;
	cache_lookup_t lookup;
	cache_write_t  cache_wr;
	mem_req_t      mem_req;
	mem_rsp_t      mem_rsp;

	dcache_controller u_controller
	(
		.clock       (clock),
		.rst_n       (rst_n),
		.proc_req    (proc_req),
		.proc_rsp    (proc_rsp),
		.lookup_addr (lookup_addr),
		.lookup      (lookup),
		.cache_wr    (cache_wr),
		.mem_req     (mem_req),
		.mem_rsp     (mem_rsp)
	);

	dcache_mem #(.INDEX_BITS(INDEX_BITS)) u_cache_mem
	(
		.clock       (clock),
		.rst_n       (rst_n),
		.lookup_addr (lookup_addr),
		.lookup      (lookup),
		.cache_wr    (cache_wr)
	);

	dmem_model #(.MEM_LATENCY(MEM_LATENCY), .MEM_ADDR_BITS(MEM_ADDR_BITS)) u_dmem
	(
		.clock   (clock),
		.rst_n   (rst_n),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
	import sys_defs_pkg::*;

	localparam int INDEX_BITS    = 4;
	localparam int MEM_LATENCY   = 4;
	localparam int MEM_ADDR_BITS = 10;
	localparam int LINES         = 1 << INDEX_BITS;
	localparam int WORDS         = 1 << MEM_ADDR_BITS;
	localparam int WAIT_LIMIT    = 50;
	localparam int RETRY_LIMIT   = 8;

	logic      clock;
	logic      rst_n;
	proc_req_t proc_req;
	proc_rsp_t proc_rsp;

	// expected memory image and cache lines
	word_t       golden     [WORDS];
	logic        line_valid [LINES];
	logic        line_dirty [LINES];
	addr_t       line_addr  [LINES];
	int unsigned lcg_state;

	dcache_top
	#(
		.INDEX_BITS    (INDEX_BITS),
		.MEM_LATENCY   (MEM_LATENCY),
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) DUT
	(
		.clock    (clock),
		.rst_n    (rst_n),
		.proc_req (proc_req),
		.proc_rsp (proc_rsp)
	);

	always #10 clock = ~clock;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) & 32'h7fff;
	endfunction

	// memory starts with the block address in both halves
	function automatic word_t init_word(input addr_t a);
		return {a, a};
	endfunction

	function automatic int line_of(input addr_t a);
		return int'(a[INDEX_BITS-1:0]);
	endfunction

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string test, input word_t exp, input word_t act);
		if (act !== exp)
		begin
			stop_with_error($sformatf("Fail %s: expected %h actual %h", test, exp, act));
		end
	endtask

	task automatic check_tag(input string test, input mem_tag_t exp, input mem_tag_t act);
		if (act !== exp)
		begin
			stop_with_error($sformatf("Fail %s: expected tag %0d actual %0d", test, exp, act));
		end
	endtask

	task automatic check_hit(input string test, input logic exp, input logic act);
		if (act !== exp)
		begin
			stop_with_error($sformatf("Fail %s: expected hit %b actual %b", test, exp, act));
		end
	endtask

	task automatic drive_req(input bus_command_e cmd, input addr_t a, input word_t d);
		@(posedge clock);
		#2;
		proc_req.command = cmd;
		proc_req.addr    = a;
		proc_req.data    = d;
	endtask

	// response is combinational so read it mid-cycle
	task automatic sample_rsp(output proc_rsp_t rsp);
		@(negedge clock);
		rsp = proc_rsp;
	endtask

	task automatic wait_fill(input string test, input mem_tag_t t, output word_t data);
		proc_rsp_t rsp;
		int        edges;
		edges = 0;
		rsp   = '0;
		// only this load is in flight so the first completion is its own
		while (rsp.tag == '0)
		begin
			drive_req(BUS_NONE, '0, '0);
			sample_rsp(rsp);
			edges++;
			if (edges > WAIT_LIMIT)
			begin
				stop_with_error($sformatf("%s: load with tag %0d never completed", test, t));
			end
		end
		check_tag(test, t, rsp.tag);
		if (edges != MEM_LATENCY)
		begin
			stop_with_error($sformatf("Fail %s: expected fill after %0d edges actual %0d",
				test, MEM_LATENCY, edges));
		end
		data = rsp.data;
	endtask

	task automatic record_fill(input addr_t a);
		line_valid[line_of(a)] = 1'b1;
		line_dirty[line_of(a)] = 1'b0;
		line_addr[line_of(a)]  = a;
	endtask

	// one processor access retried until it is done
	task automatic access(input string test, input bus_command_e cmd, input addr_t a,
		input word_t d, output word_t result);
		proc_rsp_t rsp;
		word_t     fill_data;
		int        idx;
		int        tries;
		logic      done;
		logic      exp_hit;
		logic      exp_dirty_miss;
		idx   = line_of(a);
		done  = 1'b0;
		tries = 0;
		while (!done)
		begin
			exp_hit        = line_valid[idx] && (line_addr[idx] == a);
			exp_dirty_miss = !exp_hit && line_valid[idx] && line_dirty[idx];
			drive_req(cmd, a, d);
			sample_rsp(rsp);
			check_hit(test, exp_hit, rsp.hit);
			if (rsp.hit)
			begin
				if (cmd == BUS_STORE)
				begin
					golden[a]       = d;
					line_dirty[idx] = 1'b1;
				end
				else
				begin
					check_word(test, golden[a], rsp.data);
				end
				result = rsp.data;
				done   = 1'b1;
			end
			else
			begin
				// no fill is due here, so memory takes every miss
				if (rsp.response == '0)
				begin
					stop_with_error($sformatf("%s: miss at %0d got no memory tag", test, a));
				end
				if (exp_dirty_miss)
				begin
					// victim goes back to memory so the next try misses clean
					line_valid[idx] = 1'b0;
					line_dirty[idx] = 1'b0;
				end
				else
				begin
					wait_fill(test, rsp.response, fill_data);
					check_word(test, golden[a], fill_data);
					record_fill(a);
					if (cmd == BUS_LOAD)
					begin
						result = fill_data;
						done   = 1'b1;
					end
				end
			end
			tries++;
			if (!done && tries > RETRY_LIMIT)
			begin
				stop_with_error($sformatf("%s: access to %0d did not complete", test, a));
			end
		end
	endtask

	task automatic idle_after_reset();
		proc_rsp_t rsp;
		repeat (3)
		begin
			drive_req(BUS_NONE, '0, '0);
			sample_rsp(rsp);
			check_hit("reset", 1'b0, rsp.hit);
			check_tag("reset", '0, rsp.response);
			check_tag("reset", '0, rsp.tag);
		end
	endtask

	task automatic load_miss_then_hit();
		word_t data;
		access("load_miss_hit", BUS_LOAD, addr_t'(100), '0, data);
		check_word("load_miss_hit", init_word(addr_t'(100)), data);
		access("load_miss_hit", BUS_LOAD, addr_t'(100), '0, data);
		check_word("load_miss_hit", init_word(addr_t'(100)), data);
	endtask

	task automatic store_hit();
		word_t data;
		access("store_hit", BUS_STORE, addr_t'(100), 64'hdead_beef_0123_4567, data);
		access("store_hit", BUS_LOAD, addr_t'(100), '0, data);
		check_word("store_hit", 64'hdead_beef_0123_4567, data);
	endtask

	task automatic dirty_eviction();
		word_t data;
		// 116 shares line 4 with the dirty block 100
		access("dirty_eviction", BUS_LOAD, addr_t'(116), '0, data);
		check_word("dirty_eviction", init_word(addr_t'(116)), data);
		access("dirty_eviction", BUS_LOAD, addr_t'(100), '0, data);
		check_word("dirty_eviction", 64'hdead_beef_0123_4567, data);
	endtask

	task automatic fill_backpressure();
		proc_rsp_t rsp;
		mem_tag_t  t;
		word_t     data;
		drive_req(BUS_LOAD, addr_t'(200), '0);
		sample_rsp(rsp);
		check_hit("fill_backpressure", 1'b0, rsp.hit);
		t = rsp.response;
		if (t == '0)
		begin
			stop_with_error("fill_backpressure: load miss was not accepted");
		end
		for (int i = 1; i < MEM_LATENCY; i++)
		begin
			drive_req(BUS_NONE, '0, '0);
			sample_rsp(rsp);
			check_tag("fill_backpressure", '0, rsp.tag);
		end
		// request lands in the completion cycle
		drive_req(BUS_LOAD, addr_t'(100), '0);
		sample_rsp(rsp);
		check_tag("fill_backpressure", t, rsp.tag);
		check_hit("fill_backpressure", 1'b0, rsp.hit);
		check_tag("fill_backpressure", '0, rsp.response);
		check_word("fill_backpressure", golden[200], rsp.data);
		record_fill(addr_t'(200));
		access("fill_backpressure", BUS_LOAD, addr_t'(100), '0, data);
		access("fill_backpressure", BUS_LOAD, addr_t'(200), '0, data);
	endtask

	task automatic lcg_sequence();
		addr_t        a;
		word_t        d;
		word_t        data;
		bus_command_e cmd;
		for (int n = 0; n < 80; n++)
		begin
			a   = addr_t'(lcg_next() % 40);
			cmd = (lcg_next() % 3 == 0) ? BUS_STORE : BUS_LOAD;
			d   = {lcg_next(), lcg_next()};
			access("lcg_sequence", cmd, a, d, data);
		end
	endtask

	// overall limit in case a wait loop itself stalls
	initial
	begin
		#1000000;
		stop_with_error("simulation ran past its time limit");
	end

	initial
	begin
		clock     = 1'b0;
		rst_n     = 1'b0;
		proc_req  = '0;
		lcg_state = 55;
		for (int i = 0; i < WORDS; i++)
		begin
			golden[i] = init_word(addr_t'(i));
		end
		for (int i = 0; i < LINES; i++)
		begin
			line_valid[i] = 1'b0;
			line_dirty[i] = 1'b0;
			line_addr[i]  = '0;
		end
		repeat (5) @(posedge clock);
		#2;
		rst_n = 1'b1;

		idle_after_reset();
		load_miss_then_hit();
		store_hit();
		dirty_eviction();
		fill_backpressure();
		lcg_sequence();

		$display("** PASS **");
		$finish;
	end

endmodule

// File: vlog.f
sys_defs_pkg.sv
dcache_mem.sv
dmem_model.sv
dcache_controller.sv
dcache_top.sv
tb_dcache.sv

// File: Makefile
# Verilator build and run of the data-cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build and run; a $$fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
